// File: project.f
source/scaler_pkg.sv
source/stream_slice_unit.sv
source/stream_slicer.sv
source/sample_scaler.sv
source/scaler_csr.sv
source/scaler_top.sv
bench/scaler_properties.sv
bench/tb_scaler_top.sv

// File: Bender.yml
package:
  name: scaler_subsystem

sources:
  - files:
      - source/scaler_pkg.sv
      - source/stream_slice_unit.sv
      - source/stream_slicer.sv
      - source/sample_scaler.sv
      - source/scaler_csr.sv
      - source/scaler_top.sv
  - target: test
    files:
      - bench/scaler_properties.sv
      - bench/tb_scaler_top.sv

// File: bench/tb_scaler_top.sv
//------------------------------
// testbench for scaler_top: AXI4-Lite tasks,
// stream stimulus, reference model and checks.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_scaler_top;
  localparam int TIMEOUT_CYCLES = 1000;

  logic                                    i_clk = 1'b0;
  logic                                    i_reset;
  logic                                    i_s_valid;
  logic                                    o_s_ready;
  scaler_pkg::sample_t                     i_s_data;
  logic                                    o_m_valid;
  logic                                    i_m_ready;
  scaler_pkg::result_t                     o_m_data;
  logic                                    i_axi_awvalid;
  logic                                    o_axi_awready;
  logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_awaddr;
  logic                                    i_axi_wvalid;
  logic                                    o_axi_wready;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   i_axi_wdata;
  logic [scaler_pkg::AXI_DATA_WIDTH/8-1:0] i_axi_wstrb;
  logic                                    o_axi_bvalid;
  logic                                    i_axi_bready;
  logic [1:0]                              o_axi_bresp;
  logic                                    i_axi_arvalid;
  logic                                    o_axi_arready;
  logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_araddr;
  logic                                    o_axi_rvalid;
  logic                                    i_axi_rready;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   o_axi_rdata;
  logic [1:0]                              o_axi_rresp;

  int                  seed = 32'h2ed7_b7cb;
  string               test_name;
  int                  test_errors = 0;
  int                  pass_count = 0;
  int                  fail_count = 0;
  int unsigned         prop_errors_seen = 0;
  bit                  hung = 1'b0;
  bit                  random_ready = 1'b0;
  bit                  cfg_enable = 1'b0;
  logic signed [15:0]  cfg_gain = scaler_pkg::GAIN_RESET;
  logic signed [15:0]  cfg_offset = 16'sh0000;
  scaler_pkg::sample_t stim_q [$];
  scaler_pkg::result_t expected_q [$];
  int                  cycle_count = 0;
  int                  first_in_cycle = -1;
  int                  first_out_cycle = -1;
  int                  last_out_cycle = -1;
  int                  delivered = 0;
  int                  sat_delivered = 0;
  bit                  stalled = 1'b0;
  scaler_pkg::result_t stall_data;

  scaler_top DUT (.*);

  always #4 i_clk = ~i_clk;

  // gain, offset and clamp rule under the current settings.
  function automatic scaler_pkg::result_t scale_model(input scaler_pkg::sample_t s);
    scaler_pkg::result_t r;
    int product;
    int value;
    product = int'(s) * int'(cfg_gain);
    value   = (product >>> scaler_pkg::GAIN_FRAC_BITS) + int'(cfg_offset);
    r.sat   = 1'b0;
    if (!cfg_enable) begin
      r.data = s;
    end else if (value > 32767) begin
      r.data = 16'sh7FFF;
      r.sat  = 1'b1;
    end else if (value < -32768) begin
      r.data = 16'sh8000;
      r.sat  = 1'b1;
    end else begin
      r.data = value[15:0];
    end
    return r;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic tick_timeout(inout int count, input string what);
    count++;
    if (count > TIMEOUT_CYCLES) begin
      $display("%s: timed out waiting for %s", test_name, what);
      test_errors++;
      hung = 1'b1;
    end
  endtask

  //------------------------------
  // AXI4-Lite master tasks.
  //------------------------------
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int wait_count;
    @(negedge i_clk);
    i_axi_awvalid = 1'b1;
    i_axi_wvalid  = 1'b1;
    i_axi_awaddr  = addr;
    i_axi_wdata   = data;
    i_axi_wstrb   = strb;
    wait_count = 0;
    @(posedge i_clk);
    while (!(o_axi_awready && o_axi_wready) && !hung) begin
      tick_timeout(wait_count, "write address accept");
      @(posedge i_clk);
    end
    @(negedge i_clk);
    i_axi_awvalid = 1'b0;
    i_axi_wvalid  = 1'b0;
    wait_count = 0;
    @(posedge i_clk);
    while (!o_axi_bvalid && !hung) begin
      tick_timeout(wait_count, "write response");
      @(posedge i_clk);
    end
    @(negedge i_clk);
    i_axi_bready = 1'b1;  // response waits one cycle before it is taken.
    @(posedge i_clk);
    resp = o_axi_bresp;
    @(negedge i_clk);
    i_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int wait_count;
    @(negedge i_clk);
    i_axi_arvalid = 1'b1;
    i_axi_araddr  = addr;
    wait_count = 0;
    @(posedge i_clk);
    while (!o_axi_arready && !hung) begin
      tick_timeout(wait_count, "read address accept");
      @(posedge i_clk);
    end
    @(negedge i_clk);
    i_axi_arvalid = 1'b0;
    wait_count = 0;
    @(posedge i_clk);
    while (!o_axi_rvalid && !hung) begin
      tick_timeout(wait_count, "read data");
      @(posedge i_clk);
    end
    @(negedge i_clk);
    i_axi_rready = 1'b1;  // data waits one cycle before it is taken.
    @(posedge i_clk);
    data = o_axi_rdata;
    resp = o_axi_rresp;
    @(negedge i_clk);
    i_axi_rready = 1'b0;
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp,
                             input string what);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    compare_value({what, " bresp"}, exp_resp, resp);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input string what);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    compare_value(what, exp_data, data);
    compare_value({what, " rresp"}, exp_resp, resp);
  endtask

  task automatic set_config(input bit enable, input logic [15:0] gain,
                            input logic [15:0] offset);
    write_check(scaler_pkg::ADDR_CTRL, {31'd0, enable}, 4'hF, scaler_pkg::OKAY, "ctrl");
    write_check(scaler_pkg::ADDR_GAIN, {16'd0, gain}, 4'hF, scaler_pkg::OKAY, "gain");
    write_check(scaler_pkg::ADDR_OFFSET, {16'd0, offset}, 4'hF, scaler_pkg::OKAY, "offset");
    cfg_enable = enable;
    cfg_gain   = gain;
    cfg_offset = offset;
  endtask

  //------------------------------
  // stream stimulus.
  //------------------------------
  task automatic fill_random(input int n);
    int rnd;
    @(posedge i_clk);  // ready draws happen on falling edges.
    stim_q.delete();
    repeat (n) begin
      rnd = $random(seed);
      stim_q.push_back(rnd[15:0]);
    end
  endtask

  task automatic send_samples();
    int wait_count;
    for (int k = 0; k < stim_q.size() && !hung; k++) begin
      @(negedge i_clk);
      i_s_valid = 1'b1;
      i_s_data  = stim_q[k];
      wait_count = 0;
      @(posedge i_clk);
      while (!o_s_ready && !hung) begin
        tick_timeout(wait_count, "input ready");
        @(posedge i_clk);
      end
    end
    @(negedge i_clk);
    i_s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int wait_count;
    wait_count = 0;
    while (expected_q.size() != 0 && !hung) begin
      tick_timeout(wait_count, "outputs to drain");
      @(negedge i_clk);
    end
  endtask

  always @(negedge i_clk) begin : drive_out_ready
    int rnd;
    rnd = $random(seed);
    i_m_ready = random_ready ? rnd[0] : 1'b1;
  end

  // transfers seen at the clock edge feed the model and the checks.
  always @(posedge i_clk) begin : monitor_stream
    scaler_pkg::result_t exp;
    cycle_count++;
    if (!i_reset) begin
      if (stalled) begin
        compare_value("stalled output", {1'b1, stall_data}, {o_m_valid, o_m_data});
      end
      stalled    = o_m_valid && !i_m_ready;
      stall_data = o_m_data;
      if (i_s_valid && o_s_ready) begin
        expected_q.push_back(scale_model(i_s_data));
        if (first_in_cycle < 0) begin
          first_in_cycle = cycle_count;
        end
      end
      if (o_m_valid && i_m_ready) begin
        if (expected_q.size() == 0) begin
          $display("%s: output delivered with no sample in flight", test_name);
          test_errors++;
        end else begin
          exp = expected_q.pop_front();
          compare_value("output", exp, o_m_data);
          delivered++;
          if (exp.sat) begin
            sat_delivered++;
          end
          if (first_out_cycle < 0) begin
            first_out_cycle = cycle_count;
          end
          last_out_cycle = cycle_count;
        end
      end
    end
  end

  task automatic finish_test();
    if (DUT.u_props.error_count != prop_errors_seen) begin
      $display("%s: a bound protocol assertion failed", test_name);
      test_errors++;
      prop_errors_seen = DUT.u_props.error_count;
    end
    if (test_errors == 0) begin
      $display("%s: passed", test_name);
      pass_count++;
    end else begin
      $display("%s: failed with %0d errors", test_name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  //------------------------------
  // tests.
  //------------------------------
  task automatic run_register_test();
    test_name = "register access";
    read_check(scaler_pkg::ADDR_CTRL, 32'h0, scaler_pkg::OKAY, "ctrl after reset");
    read_check(scaler_pkg::ADDR_GAIN, 32'h100, scaler_pkg::OKAY, "gain after reset");
    read_check(scaler_pkg::ADDR_OFFSET, 32'h0, scaler_pkg::OKAY, "offset after reset");
    read_check(scaler_pkg::ADDR_SAMPLE_COUNT, 32'h0, scaler_pkg::OKAY, "sample count");
    read_check(scaler_pkg::ADDR_SAT_COUNT, 32'h0, scaler_pkg::OKAY, "sat count");
    write_check(scaler_pkg::ADDR_GAIN, 32'h0000_1234, 4'hF, scaler_pkg::OKAY, "gain");
    read_check(scaler_pkg::ADDR_GAIN, 32'h1234, scaler_pkg::OKAY, "gain readback");
    write_check(scaler_pkg::ADDR_GAIN, 32'h0000_AB99, 4'h2, scaler_pkg::OKAY, "gain byte 1");
    read_check(scaler_pkg::ADDR_GAIN, 32'hAB34, scaler_pkg::OKAY, "gain after byte 1");
    write_check(scaler_pkg::ADDR_OFFSET, 32'hFFFF_FF80, 4'h1, scaler_pkg::OKAY, "offset byte 0");
    read_check(scaler_pkg::ADDR_OFFSET, 32'h0080, scaler_pkg::OKAY, "offset after byte 0");
    write_check(scaler_pkg::ADDR_OFFSET, 32'h1234_5678, 4'hC, scaler_pkg::OKAY, "offset top");
    read_check(scaler_pkg::ADDR_OFFSET, 32'h0080, scaler_pkg::OKAY, "offset after top");
    write_check(8'h20, 32'hFFFF_FFFF, 4'hF, scaler_pkg::SLVERR, "unmapped write");
    read_check(8'h20, 32'h0, scaler_pkg::SLVERR, "unmapped read");
    set_config(1'b0, scaler_pkg::GAIN_RESET, 16'h0000);
    finish_test();
  endtask

  task automatic scale_run(input logic [15:0] gain, input logic [15:0] offset);
    stim_q.delete();
    stim_q.push_back(16'sh7FFF);
    stim_q.push_back(16'sh8000);
    stim_q.push_back(16'sh0000);
    stim_q.push_back(16'sh0001);
    stim_q.push_back(16'shFFFF);
    stim_q.push_back(16'sh4E20);  // 20000.
    stim_q.push_back(16'shB1E0);  // -20000.
    stim_q.push_back(16'sh3039);
    set_config(1'b1, gain, offset);
    send_samples();
    wait_drain();
  endtask

  task automatic run_stream_tests();
    test_name = "bypass";
    set_config(1'b0, 16'h0300, 16'h0011);
    fill_random(50);
    send_samples();
    wait_drain();
    finish_test();

    test_name = "scaling and saturation";
    scale_run(16'h0180, 16'd100);   // gain 1.5 clamps at both ends.
    scale_run(16'hFE00, 16'hFFCE);  // -2.0 and -50.
    scale_run(16'h0040, 16'h8300);  // 0.25 and -32000.
    finish_test();

    test_name = "back-pressure";
    set_config(1'b1, 16'h00C0, 16'd7);
    fill_random(200);
    random_ready = 1'b1;
    send_samples();
    wait_drain();
    random_ready = 1'b0;
    finish_test();

    test_name = "latency and throughput";
    repeat (2) @(negedge i_clk);
    first_in_cycle  = -1;
    first_out_cycle = -1;
    fill_random(16);
    send_samples();
    wait_drain();
    compare_value("first output latency",
                  scaler_pkg::IN_STAGES + 1 + scaler_pkg::OUT_STAGES,
                  first_out_cycle - first_in_cycle);
    compare_value("output spacing", 15, last_out_cycle - first_out_cycle);
    finish_test();
  endtask

  task automatic run_statistics_test();
    test_name = "statistics";
    read_check(scaler_pkg::ADDR_SAMPLE_COUNT, delivered, scaler_pkg::OKAY, "sample count");
    read_check(scaler_pkg::ADDR_SAT_COUNT, sat_delivered, scaler_pkg::OKAY, "sat count");
    write_check(scaler_pkg::ADDR_SAMPLE_COUNT, 32'h5A5A_5A5A, 4'hF, scaler_pkg::OKAY,
                "sample clear");
    read_check(scaler_pkg::ADDR_SAMPLE_COUNT, 32'h0, scaler_pkg::OKAY, "cleared sample count");
    write_check(scaler_pkg::ADDR_SAT_COUNT, 32'hFFFF_FFFF, 4'hF, scaler_pkg::OKAY, "sat clear");
    read_check(scaler_pkg::ADDR_SAT_COUNT, 32'h0, scaler_pkg::OKAY, "cleared sat count");
    delivered     = 0;
    sat_delivered = 0;
    finish_test();
  endtask

  initial begin
    i_reset       = 1'b1;
    i_s_valid     = 1'b0;
    i_s_data      = '0;
    i_m_ready     = 1'b1;
    i_axi_awvalid = 1'b0;
    i_axi_awaddr  = '0;
    i_axi_wvalid  = 1'b0;
    i_axi_wdata   = '0;
    i_axi_wstrb   = '0;
    i_axi_bready  = 1'b0;
    i_axi_arvalid = 1'b0;
    i_axi_araddr  = '0;
    i_axi_rready  = 1'b0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    run_register_test();
    if (!hung) begin
      run_stream_tests();
    end
    if (!hung) begin
      run_statistics_test();
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/scaler_properties.sv
//------------------------------
// stream and AXI4-Lite protocol assertions,
// bound into scaler_top.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_properties (
  input var                      i_clk,
  input var                      i_reset,
  input var                      i_s_ready,
  input var                      i_out_valid,
  input var                      i_out_ready,
  input var scaler_pkg::result_t i_out_data,
  input var                      i_bvalid,
  input var                      i_bready,
  input var                      i_rvalid,
  input var                      i_rready,
  input var logic [31:0]         i_rdata
);
  int unsigned error_count = 0;  // assertion failures so far.

  out_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data))
    else begin
      $error("stream output changed while stalled");
      error_count++;
    end

  bvalid_held: assert property (@(posedge i_clk) disable iff (i_reset)
    i_bvalid && !i_bready |=> i_bvalid)
    else begin
      $error("write response dropped before bready");
      error_count++;
    end

  rvalid_held: assert property (@(posedge i_clk) disable iff (i_reset)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else begin
      $error("read response dropped or changed before rready");
      error_count++;
    end

  // every valid flag is cleared by a reset edge.
  reset_idle: assert property (@(posedge i_clk)
    i_reset |=> !i_out_valid && !i_bvalid && !i_rvalid && !i_s_ready)
    else begin
      $error("valid output high during reset");
      error_count++;
    end

endmodule

bind scaler_top scaler_properties u_props (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_s_ready   (o_s_ready),
  .i_out_valid (o_m_valid),
  .i_out_ready (i_m_ready),
  .i_out_data  (o_m_data),
  .i_bvalid    (o_axi_bvalid),
  .i_bready    (i_axi_bready),
  .i_rvalid    (o_axi_rvalid),
  .i_rready    (i_axi_rready),
  .i_rdata     (o_axi_rdata)
);

`default_nettype wire

// File: source/scaler_top.sv
//------------------------------
// top level: csr, input slicer, scaler, output slicer.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_top (
  input  var                                          i_clk,
  input  var                                          i_reset,
  input  var                                          i_s_valid,
  output var                                          o_s_ready,
  input  var scaler_pkg::sample_t                     i_s_data,
  output var                                          o_m_valid,
  input  var                                          i_m_ready,
  output var scaler_pkg::result_t                     o_m_data,
  input  var                                          i_axi_awvalid,
  output var                                          o_axi_awready,
  input  var logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_awaddr,
  input  var                                          i_axi_wvalid,
  output var                                          o_axi_wready,
  input  var logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   i_axi_wdata,
  input  var logic [scaler_pkg::AXI_DATA_WIDTH/8-1:0] i_axi_wstrb,
  output var                                          o_axi_bvalid,
  input  var                                          i_axi_bready,
  output var logic [1:0]                              o_axi_bresp,
  input  var                                          i_axi_arvalid,
  output var                                          o_axi_arready,
  input  var logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_araddr,
  output var                                          o_axi_rvalid,
  input  var                                          i_axi_rready,
  output var logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   o_axi_rdata,
  output var logic [1:0]                              o_axi_rresp
);
  logic                in_valid;
  logic                in_ready;
  scaler_pkg::sample_t in_data;
  logic                sc_valid;
  logic                sc_ready;
  scaler_pkg::result_t sc_data;
  logic                enable;
  logic signed [15:0]  gain;
  logic signed [15:0]  offset;

  scaler_csr u_csr (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_axi_awvalid (i_axi_awvalid), .o_axi_awready (o_axi_awready),
    .i_axi_awaddr  (i_axi_awaddr),
    .i_axi_wvalid  (i_axi_wvalid),  .o_axi_wready  (o_axi_wready),
    .i_axi_wdata   (i_axi_wdata),   .i_axi_wstrb   (i_axi_wstrb),
    .o_axi_bvalid  (o_axi_bvalid),  .i_axi_bready  (i_axi_bready),
    .o_axi_bresp   (o_axi_bresp),
    .i_axi_arvalid (i_axi_arvalid), .o_axi_arready (o_axi_arready),
    .i_axi_araddr  (i_axi_araddr),
    .o_axi_rvalid  (o_axi_rvalid),  .i_axi_rready  (i_axi_rready),
    .o_axi_rdata   (o_axi_rdata),   .o_axi_rresp   (o_axi_rresp),
    .o_enable (enable), .o_gain (gain), .o_offset (offset),
    .i_out_valid (o_m_valid), .i_out_ready (i_m_ready), .i_out_sat (o_m_data.sat)
  );

  //------------------------------
  // stream path.
  //------------------------------
  stream_slicer #(
    .TYPE (scaler_pkg::sample_t), .STAGES (scaler_pkg::IN_STAGES)
  ) u_in_slicer (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_valid (i_s_valid), .o_ready (o_s_ready), .i_data (i_s_data),
    .o_valid (in_valid),  .i_ready (in_ready),  .o_data (in_data)
  );

  sample_scaler u_scaler (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_valid (in_valid), .o_ready (in_ready), .i_data (in_data),
    .o_valid (sc_valid), .i_ready (sc_ready), .o_data (sc_data),
    .i_enable (enable), .i_gain (gain), .i_offset (offset)
  );

  stream_slicer #(
    .TYPE (scaler_pkg::result_t), .STAGES (scaler_pkg::OUT_STAGES)
  ) u_out_slicer (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_valid (sc_valid),  .o_ready (sc_ready),  .i_data (sc_data),
    .o_valid (o_m_valid), .i_ready (i_m_ready), .o_data (o_m_data)
  );

endmodule

`default_nettype wire

// File: source/scaler_csr.sv
//------------------------------
// AXI4-Lite register block: settings
// and output statistics counters.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_csr (
  input  var                                          i_clk,
  input  var                                          i_reset,
  input  var                                          i_axi_awvalid,
  output var                                          o_axi_awready,
  input  var logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_awaddr,
  input  var                                          i_axi_wvalid,
  output var                                          o_axi_wready,
  input  var logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   i_axi_wdata,
  input  var logic [scaler_pkg::AXI_DATA_WIDTH/8-1:0] i_axi_wstrb,
  output var                                          o_axi_bvalid,
  input  var                                          i_axi_bready,
  output var logic [1:0]                              o_axi_bresp,
  input  var                                          i_axi_arvalid,
  output var                                          o_axi_arready,
  input  var logic [scaler_pkg::AXI_ADDR_WIDTH-1:0]   i_axi_araddr,
  output var                                          o_axi_rvalid,
  input  var                                          i_axi_rready,
  output var logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   o_axi_rdata,
  output var logic [1:0]                              o_axi_rresp,
  output var                                          o_enable,
  output var logic signed [15:0]                      o_gain,
  output var logic signed [15:0]                      o_offset,
  input  var                                          i_out_valid,
  input  var                                          i_out_ready,
  input  var                                          i_out_sat
);
  logic                                    enable;
  logic signed [15:0]                      gain;
  logic signed [15:0]                      offset;
  logic [31:0]                             sample_count;
  logic [31:0]                             sat_count;
  logic                                    bvalid;
  logic [1:0]                              bresp;
  logic                                    rvalid;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   rdata;
  logic [1:0]                              rresp;
  logic                                    wr_fire;
  logic                                    rd_fire;
  logic                                    out_fire;
  logic                                    wr_known;
  logic                                    rd_known;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   rd_value;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   gain_merged;
  logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   offset_merged;

  // byte-wise update under wstrb.
  function automatic logic [scaler_pkg::AXI_DATA_WIDTH-1:0] merge(
    input logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   old_value,
    input logic [scaler_pkg::AXI_DATA_WIDTH-1:0]   new_value,
    input logic [scaler_pkg::AXI_DATA_WIDTH/8-1:0] strb
  );
    logic [scaler_pkg::AXI_DATA_WIDTH-1:0] value;
    value = old_value;
    for (int i = 0; i < scaler_pkg::AXI_DATA_WIDTH / 8; i++) begin
      if (strb[i]) begin
        value[8*i+:8] = new_value[8*i+:8];
      end
    end
    return value;
  endfunction

  //------------------------------
  // write channel.
  //------------------------------
  assign wr_fire  = i_axi_awvalid && i_axi_wvalid && !bvalid;
  assign out_fire = i_out_valid && i_out_ready;

  always_comb begin
    gain_merged   = merge({16'h0000, gain}, i_axi_wdata, i_axi_wstrb);
    offset_merged = merge({16'h0000, offset}, i_axi_wdata, i_axi_wstrb);
    case (i_axi_awaddr)
      scaler_pkg::ADDR_CTRL, scaler_pkg::ADDR_GAIN, scaler_pkg::ADDR_OFFSET,
      scaler_pkg::ADDR_SAMPLE_COUNT, scaler_pkg::ADDR_SAT_COUNT: wr_known = 1'b1;
      default: wr_known = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      bvalid <= 1'b0;
      enable <= 1'b0;
      gain   <= scaler_pkg::GAIN_RESET;
      offset <= 16'sh0000;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (i_axi_bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire && i_axi_awaddr == scaler_pkg::ADDR_CTRL && i_axi_wstrb[0]) begin
        enable <= i_axi_wdata[0];
      end
      if (wr_fire && i_axi_awaddr == scaler_pkg::ADDR_GAIN) begin
        gain <= gain_merged[15:0];
      end
      if (wr_fire && i_axi_awaddr == scaler_pkg::ADDR_OFFSET) begin
        offset <= offset_merged[15:0];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      bresp <= wr_known ? scaler_pkg::OKAY : scaler_pkg::SLVERR;
    end
  end

  // counters wrap; a clearing write beats a count.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      sample_count <= '0;
      sat_count    <= '0;
    end else begin
      if (wr_fire && i_axi_awaddr == scaler_pkg::ADDR_SAMPLE_COUNT) begin
        sample_count <= '0;
      end else if (out_fire) begin
        sample_count <= sample_count + 32'd1;
      end
      if (wr_fire && i_axi_awaddr == scaler_pkg::ADDR_SAT_COUNT) begin
        sat_count <= '0;
      end else if (out_fire && i_out_sat) begin
        sat_count <= sat_count + 32'd1;
      end
    end
  end

  //------------------------------
  // read channel.
  //------------------------------
  assign rd_fire = i_axi_arvalid && !rvalid;

  always_comb begin
    rd_value = '0;
    rd_known = 1'b1;
    case (i_axi_araddr)
      scaler_pkg::ADDR_CTRL:         rd_value[0] = enable;
      scaler_pkg::ADDR_GAIN:         rd_value[15:0] = gain;
      scaler_pkg::ADDR_OFFSET:       rd_value[15:0] = offset;
      scaler_pkg::ADDR_SAMPLE_COUNT: rd_value = sample_count;
      scaler_pkg::ADDR_SAT_COUNT:    rd_value = sat_count;
      default:                       rd_known = 1'b0;  // reads zero.
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (i_axi_rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      rdata <= rd_value;
      rresp <= rd_known ? scaler_pkg::OKAY : scaler_pkg::SLVERR;
    end
  end

  assign o_axi_awready = wr_fire;  // both channels taken together.
  assign o_axi_wready  = wr_fire;
  assign o_axi_bvalid  = bvalid;
  assign o_axi_bresp   = bresp;
  assign o_axi_arready = !rvalid;
  assign o_axi_rvalid  = rvalid;
  assign o_axi_rdata   = rdata;
  assign o_axi_rresp   = rresp;
  assign o_enable      = enable;
  assign o_gain        = gain;
  assign o_offset      = offset;

endmodule

`default_nettype wire

// File: source/sample_scaler.sv
//------------------------------
// gain, offset and saturation, one register stage.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_scaler (
  input  var                      i_clk,
  input  var                      i_reset,
  input  var                      i_valid,
  output var                      o_ready,
  input  var scaler_pkg::sample_t i_data,
  output var                      o_valid,
  input  var                      i_ready,
  output var scaler_pkg::result_t o_data,
  input  var                      i_enable,
  input  var logic signed [15:0]  i_gain,
  input  var logic signed [15:0]  i_offset
);
  logic signed [31:0]  product;
  logic signed [31:0]  scaled;
  logic signed [32:0]  sum;
  scaler_pkg::result_t result;
  scaler_pkg::result_t out_data;
  logic                out_valid;
  logic                load;

  //------------------------------
  // arithmetic.
  //------------------------------
  always_comb begin
    product = i_data * i_gain;                           // full-width signed.
    scaled  = product >>> scaler_pkg::GAIN_FRAC_BITS;
    sum     = scaled + i_offset;
    if (!i_enable) begin
      result.data = i_data;  // bypass.
      result.sat  = 1'b0;
    end else if (sum > 33'sd32767) begin
      result.data = 16'sh7FFF;
      result.sat  = 1'b1;
    end else if (sum < -33'sd32768) begin
      result.data = 16'sh8000;
      result.sat  = 1'b1;
    end else begin
      result.data = sum[15:0];
      result.sat  = 1'b0;
    end
  end

  assign o_ready = !out_valid || i_ready;  // empty or draining now.
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      out_valid <= 1'b0;
    end else if (o_ready) begin
      out_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      out_data <= result;
    end
  end

  assign o_valid = out_valid;
  assign o_data  = out_data;

endmodule

`default_nettype wire

// File: source/stream_slicer.sv
//------------------------------
// chain of slice units, any depth and payload.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module stream_slicer #(
  parameter type TYPE   = logic [7:0],
  parameter int  STAGES = 1
)(
  input  var      i_clk,
  input  var      i_reset,
  input  var      i_valid,
  output var      o_ready,
  input  var TYPE i_data,
  output var      o_valid,
  input  var      i_ready,
  output var TYPE o_data
);
  // index 0 faces the input, index STAGES the output.
  logic valid [STAGES+1];
  logic ready [STAGES+1];
  TYPE  data  [STAGES+1];

  assign valid[0]      = i_valid;
  assign data[0]       = i_data;
  assign o_ready       = ready[0];
  assign ready[STAGES] = i_ready;
  assign o_valid       = valid[STAGES];
  assign o_data        = data[STAGES];

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    stream_slice_unit #(
      .TYPE (TYPE)
    ) u_unit (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (valid[i]),
      .o_ready (ready[i]),
      .i_data  (data[i]),
      .o_valid (valid[i+1]),
      .i_ready (ready[i+1]),
      .o_data  (data[i+1])
    );
  end

endmodule

`default_nettype wire

// File: source/stream_slice_unit.sv
//------------------------------
// full-bandwidth valid/ready register stage
// with a skid register and registered ready.
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module stream_slice_unit #(
  parameter type TYPE = logic [7:0]
)(
  input  var      i_clk,
  input  var      i_reset,
  input  var      i_valid,
  output var      o_ready,
  input  var TYPE i_data,
  output var      o_valid,
  input  var      i_ready,
  output var TYPE o_data
);
  logic main_valid;
  logic skid_valid;
  logic skid_valid_next;
  logic ready;
  TYPE  main_data;
  TYPE  skid_data;
  logic push;
  logic main_load;

  assign push      = i_valid && ready;
  assign main_load = !main_valid || i_ready;  // main register free next edge.

  // skid holds an item only while the output stalls.
  always_comb begin
    skid_valid_next = skid_valid;
    if (skid_valid && main_load) begin
      skid_valid_next = 1'b0;
    end else if (push && !main_load) begin
      skid_valid_next = 1'b1;
    end
  end

  //------------------------------
  // control flags.
  //------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready      <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid || push;
      end
      skid_valid <= skid_valid_next;
      ready      <= !skid_valid_next;
    end
  end

  // payload registers.
  always_ff @(posedge i_clk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : i_data;  // skid is older.
    end
    if (push && !main_load) begin
      skid_data <= i_data;
    end
  end

  assign o_ready = ready;
  assign o_valid = main_valid;
  assign o_data  = main_data;

endmodule

`default_nettype wire

// File: source/scaler_pkg.sv
//------------------------------
// sample and result types, register map,
// bus widths and pipeline depths.
//------------------------------
`default_nettype none

package scaler_pkg;

  // bus and pipeline sizes.
  localparam int AXI_ADDR_WIDTH = 8;
  localparam int AXI_DATA_WIDTH = 32;
  localparam int GAIN_FRAC_BITS = 8;  // Q8.8 gain.
  localparam int IN_STAGES      = 2;
  localparam int OUT_STAGES     = 1;

  //------------------------------
  // register map.
  //------------------------------
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CTRL         = 8'h00;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_GAIN         = 8'h04;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_OFFSET       = 8'h08;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_SAMPLE_COUNT = 8'h0C;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_SAT_COUNT    = 8'h10;

  localparam logic [15:0] GAIN_RESET = 16'h0100;  // 1.0.

  // response codes.
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  typedef logic signed [15:0] sample_t;

  typedef struct packed {
    logic signed [15:0] data;
    logic               sat;   // result was clamped.
  } result_t;

endpackage

`default_nettype wire
